// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_debug \
  -f uart_debug.f -o sim_uart_debug &&
./obj_dir/sim_uart_debug || exit 1

// ==== sim/tb_uart_debug.sv ====
// Host UART runs at 16 clocks per bit; the first mismatch or timeout ends the run
`timescale 1ns/1ns
module tb_uart_debug;

  localparam int unsigned ClksPerBit = 16;
  localparam int unsigned MemDepth   = 1024;
  localparam int unsigned XferMax    = 24;
  localparam int unsigned WaitLimit  = 20000;
  localparam int unsigned ExtLimit   = 50000;
  localparam logic [7:0]  AckByte    = 8'h06;
  localparam logic [7:0]  EotByte    = 8'h04;
  localparam logic [7:0]  ReadByte   = 8'h11;
  localparam logic [7:0]  WriteByte  = 8'h12;
  localparam logic [7:0]  ExecByte   = 8'h13;
  localparam logic [7:0]  EocByte    = 8'h14;

  logic                     clk;
  logic                     rst_i;
  logic                     uart_rx_i;
  logic                     uart_tx_o;
  uart_debug_pkg::mem_req_t ext_req_i;
  uart_debug_pkg::mem_rsp_t ext_rsp_o;
  logic                     eoc_i;
  logic [63:0]              exit_code_i;
  logic                     launch_o;
  logic [63:0]              entry_o;

  integer               seed;
  logic                 uart_done;
  int                   ext_stalls;
  int                   k;
  logic [8*XferMax-1:0] host_data;
  logic [8*XferMax-1:0] link_data;
  logic [8*XferMax-1:0] ext_data;
  logic [63:0]          entry;
  logic [63:0]          exit_code;

  uart_debug_top #(
    .ClksPerBit(ClksPerBit),
    .MemDepth  (MemDepth)
  ) uut (
    .clk        (clk),
    .rst_i      (rst_i),
    .uart_rx_i  (uart_rx_i),
    .uart_tx_o  (uart_tx_o),
    .ext_req_i  (ext_req_i),
    .ext_rsp_o  (ext_rsp_o),
    .eoc_i      (eoc_i),
    .exit_code_i(exit_code_i),
    .launch_o   (launch_o),
    .entry_o    (entry_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic fail_run(input string msg);
    $display("%s at %0t", msg, $time);
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Inputs move 2 ns after the rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  ////////////////////
  // Host UART
  ////////////////////

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      uart_rx_i = frame[i];
      step(ClksPerBit);
    end
  endtask

  // Header fields go out LSB first
  task automatic send_field(input logic [63:0] v);
    int i;
    for (i = 0; i < 8; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  // Samples on the falling clock edge, mid-bit
  task automatic recv_byte(output logic [7:0] b);
    int n;
    int i;
    n = 0;
    @(negedge clk);
    while (uart_tx_o !== 1'b0 && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (uart_tx_o !== 1'b0) fail_run("no start bit on uart_tx_o before timeout");
    repeat (ClksPerBit / 2) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      repeat (ClksPerBit) @(negedge clk);
      b[i] = uart_tx_o;
    end
    repeat (ClksPerBit) @(negedge clk);
    if (uart_tx_o !== 1'b1) fail_run("stop bit on uart_tx_o is low");
  endtask

  task automatic expect_byte(input string name, input logic [7:0] exp);
    logic [7:0] b;
    recv_byte(b);
    check_value(name, exp, b);
  endtask

  task automatic host_write(input logic [63:0] addr, input int len,
                            input logic [8*XferMax-1:0] data);
    int i;
    step(1);
    fork
      begin
        send_byte(WriteByte);
        send_field(addr);
        send_field(64'(len));
        for (i = 0; i < len; i++) begin
          send_byte(data[8*i +: 8]);
        end
      end
      begin
        expect_byte("uart_tx_o ACK", AckByte);
        expect_byte("uart_tx_o EOT", EotByte);
      end
    join
  endtask

  task automatic host_read(input logic [63:0] addr, input int len,
                           input logic [8*XferMax-1:0] data);
    int j;
    step(1);
    fork
      begin
        send_byte(ReadByte);
        send_field(addr);
        send_field(64'(len));
      end
      begin
        expect_byte("uart_tx_o ACK", AckByte);
        for (j = 0; j < len; j++) begin
          expect_byte($sformatf("uart_tx_o data %0d", j), data[8*j +: 8]);
        end
        expect_byte("uart_tx_o EOT", EotByte);
      end
    join
  endtask

  ////////////////////
  // External port
  ////////////////////

  task automatic wait_ext_grant();
    int n;
    n = 0;
    @(negedge clk);
    while (!ext_rsp_o.gnt && n < WaitLimit) begin
      ext_stalls++;
      @(negedge clk);
      n++;
    end
    if (!ext_rsp_o.gnt) fail_run("external port was never granted");
  endtask

  task automatic ext_write(input int addr, input logic [7:0] data);
    ext_req_i.valid = 1'b1;
    ext_req_i.write = 1'b1;
    ext_req_i.addr  = uart_debug_pkg::mem_addr_t'(addr);
    ext_req_i.wdata = data;
    wait_ext_grant();
    step(1);
    ext_req_i = '0;
  endtask

  task automatic ext_read(input int addr, input logic [7:0] exp);
    ext_req_i.valid = 1'b1;
    ext_req_i.write = 1'b0;
    ext_req_i.addr  = uart_debug_pkg::mem_addr_t'(addr);
    ext_req_i.wdata = 8'h00;
    wait_ext_grant();
    step(1);
    ext_req_i = '0;
    // One cycle after the granted edge
    @(negedge clk);
    check_value("ext_rsp_o.rvalid", 64'd1, ext_rsp_o.rvalid);
    check_value("ext_rsp_o.rdata", exp, ext_rsp_o.rdata);
    step(1);
  endtask

  task automatic wait_launch(input logic [63:0] exp);
    int n;
    n = 0;
    @(negedge clk);
    while (!launch_o && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!launch_o) fail_run("launch_o did not pulse after exec");
    check_value("entry_o", exp, entry_o);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    seed        = 32'he703_7941;
    rst_i       = 1'b1;
    uart_rx_i   = 1'b1;
    ext_req_i   = '0;
    eoc_i       = 1'b0;
    exit_code_i = '0;
    uart_done   = 1'b0;
    ext_stalls  = 0;
    step(16);
    rst_i = 1'b0;

    // Idle outputs after reset
    @(negedge clk);
    check_value("uart_tx_o", 64'd1, uart_tx_o);
    check_value("launch_o", 64'd0, launch_o);
    check_value("ext_rsp_o.gnt", 64'd0, ext_rsp_o.gnt);
    check_value("eng_rsp.gnt", 64'd0, uut.eng_rsp.gnt);

    step(1);
    fork
      send_byte(AckByte);
      expect_byte("uart_tx_o ACK", AckByte);
    join

    for (k = 0; k < XferMax; k++) begin
      host_data[8*k +: 8] = 8'($random(seed));
      link_data[8*k +: 8] = 8'($random(seed));
      ext_data[8*k +: 8]  = (k < 16) ? 8'($random(seed)) : 8'h00;
    end
    host_write(64'd100, XferMax, host_data);
    host_read(64'd100, XferMax, host_data);
    host_read(64'd100, 0, '0);

    // External writes keep colliding with the UART write
    fork
      begin
        host_write(64'd600, XferMax, link_data);
        uart_done = 1'b1;
      end
      begin
        step(1);
        k = 0;
        while (!uart_done && k < ExtLimit) begin
          ext_write(500 + k % 16, ext_data[8*(k % 16) +: 8]);
          k++;
        end
        if (!uart_done) fail_run("UART write did not finish during external traffic");
      end
    join
    if (ext_stalls == 0) fail_run("external port never waited for the engine");
    host_read(64'd500, 16, ext_data);
    step(1);
    for (k = 0; k < XferMax; k++) begin
      ext_read(600 + k, link_data[8*k +: 8]);
    end

    entry = {32'($random(seed)), 32'($random(seed))};
    step(1);
    fork
      begin
        send_byte(ExecByte);
        send_field(entry);
      end
      expect_byte("uart_tx_o ACK", AckByte);
      wait_launch(entry);
    join

    exit_code = {32'($random(seed)), 32'($random(seed))};
    step(1);
    fork
      begin
        eoc_i       = 1'b1;
        exit_code_i = exit_code;
        step(1);
        eoc_i = 1'b0;
      end
      begin
        expect_byte("uart_tx_o EOC", EocByte);
        for (k = 0; k < 8; k++) begin
          expect_byte($sformatf("uart_tx_o exit code %0d", k), exit_code[8*k +: 8]);
        end
      end
    join

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== sim/uart_debug_assert.sv ====
// Bound into uart_debug_top; checks are idle while rst_i is high
`timescale 1ns/1ns
module uart_debug_assert (
  input logic                          clk,
  input logic                          rst_i,
  input uart_debug_pkg::mem_req_t      eng_req_i,
  input uart_debug_pkg::mem_rsp_t      eng_rsp_i,
  input uart_debug_pkg::mem_req_t      ext_req_i,
  input uart_debug_pkg::mem_rsp_t      ext_rsp_i,
  input logic                          launch_i,
  input logic                          uart_tx_i,
  input logic                          tx_busy_i,
  input uart_debug_pkg::engine_state_e state_i
);

  ////////////////////
  // Arbiter
  ////////////////////

  single_grant: assert property (@(posedge clk) disable iff (rst_i)
    !(eng_rsp_i.gnt && ext_rsp_i.gnt))
    else $error("engine and external grants are high together");

  // Read data one cycle after each granted read, and only then
  eng_rd_latency: assert property (@(posedge clk) disable iff (rst_i)
    (eng_rsp_i.gnt && !eng_req_i.write) |=> eng_rsp_i.rvalid)
    else $error("engine read data missing one cycle after grant");

  eng_rd_origin: assert property (@(posedge clk) disable iff (rst_i)
    eng_rsp_i.rvalid |-> $past(eng_rsp_i.gnt && !eng_req_i.write))
    else $error("engine rvalid without a granted read");

  ext_rd_latency: assert property (@(posedge clk) disable iff (rst_i)
    (ext_rsp_i.gnt && !ext_req_i.write) |=> ext_rsp_i.rvalid)
    else $error("external read data missing one cycle after grant");

  ext_rd_origin: assert property (@(posedge clk) disable iff (rst_i)
    ext_rsp_i.rvalid |-> $past(ext_rsp_i.gnt && !ext_req_i.write))
    else $error("external rvalid without a granted read");

  ////////////////////
  // Engine outputs
  ////////////////////

  launch_pulse: assert property (@(posedge clk) disable iff (rst_i)
    launch_i |=> !launch_i)
    else $error("launch_o is longer than one cycle");

  // An idle engine never starts the transmitter, so the line stays high
  tx_idle_high: assert property (@(posedge clk) disable iff (rst_i)
    (state_i == uart_debug_pkg::ST_IDLE && !tx_busy_i) |=>
      (state_i != uart_debug_pkg::ST_IDLE || uart_tx_i))
    else $error("uart_tx_o left idle while the engine stayed idle");

endmodule

bind uart_debug_top uart_debug_assert u_assert (
  .clk      (clk),
  .rst_i    (rst_i),
  .eng_req_i(eng_req),
  .eng_rsp_i(eng_rsp),
  .ext_req_i(ext_req_i),
  .ext_rsp_i(ext_rsp_o),
  .launch_i (launch_o),
  .uart_tx_i(uart_tx_o),
  .tx_busy_i(tx_busy),
  .state_i  (u_engine.state_q)
);

// ==== source/scratch_mem_arbiter.sv ====
// Engine has fixed priority; requests must hold until gnt; addresses wrap modulo MemDepth
`timescale 1ns/1ns
module scratch_mem_arbiter #(
  parameter int unsigned MemDepth = 1024
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  uart_debug_pkg::mem_req_t eng_req_i,
  output uart_debug_pkg::mem_rsp_t eng_rsp_o,
  input  uart_debug_pkg::mem_req_t ext_req_i,
  output uart_debug_pkg::mem_rsp_t ext_rsp_o
);

  logic [7:0]                mem_q [MemDepth];
  logic                      eng_gnt;
  logic                      ext_gnt;
  uart_debug_pkg::mem_req_t  sel_req;
  uart_debug_pkg::mem_addr_t idx;
  logic [7:0]                rdata_q;
  logic                      rd_valid_q;
  // Set when the pending read data belongs to the external port
  logic                      rd_ext_q;

  assign eng_gnt = eng_req_i.valid;
  assign ext_gnt = ext_req_i.valid & ~eng_req_i.valid;
  assign sel_req = eng_gnt ? eng_req_i : ext_req_i;
  assign idx     = uart_debug_pkg::mem_addr_t'(sel_req.addr % MemDepth);

  always_ff @(posedge clk) begin
    if ((eng_gnt || ext_gnt) && sel_req.write) mem_q[idx] <= sel_req.wdata;
    if ((eng_gnt || ext_gnt) && !sel_req.write) rdata_q <= mem_q[idx];
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rd_valid_q <= 1'b0;
      rd_ext_q   <= 1'b0;
    end else begin
      rd_valid_q <= (eng_gnt || ext_gnt) && !sel_req.write;
      rd_ext_q   <= ext_gnt;
    end
  end

  assign eng_rsp_o = '{gnt: eng_gnt, rvalid: rd_valid_q & ~rd_ext_q, rdata: rdata_q};
  assign ext_rsp_o = '{gnt: ext_gnt, rvalid: rd_valid_q & rd_ext_q, rdata: rdata_q};

endmodule

// ==== source/uart_debug_engine.sv ====
// Addresses keep MemAddrBits low bits; bytes arriving while not awaited are dropped
`timescale 1ns/1ns
module uart_debug_engine (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     rx_valid_i,
  input  logic [7:0]               rx_byte_i,
  input  logic                     tx_busy_i,
  output logic                     tx_start_o,
  output logic [7:0]               tx_byte_o,
  output uart_debug_pkg::mem_req_t mem_req_o,
  input  uart_debug_pkg::mem_rsp_t mem_rsp_i,
  input  logic                     eoc_i,
  input  logic [63:0]              exit_code_i,
  output logic                     launch_o,
  output logic [63:0]              entry_o
);

  localparam int unsigned CntBits = $clog2(uart_debug_pkg::HeaderBytes);
  localparam logic [CntBits-1:0] CntLast = CntBits'(uart_debug_pkg::HeaderBytes - 1);

  uart_debug_pkg::engine_state_e state_q;
  uart_debug_pkg::dbg_cmd_e      cmd_q;
  uart_debug_pkg::mem_addr_t     addr_q;
  logic [CntBits-1:0]            cnt_q;
  logic [63:0]                   hdr_q;
  logic [63:0]                   len_q;
  logic [63:0]                   hdr_shift;
  logic [7:0]                    data_q;
  logic                          data_vld_q;
  logic                          last_hdr;

  // Header fields arrive LSB first
  assign hdr_shift = {rx_byte_i, hdr_q[63:8]};
  assign last_hdr  = rx_valid_i && (cnt_q == CntLast);

  ////////////////////
  // Outputs
  ////////////////////

  always_comb begin
    tx_start_o = 1'b0;
    tx_byte_o  = uart_debug_pkg::CODE_ACK;
    case (state_q)
      uart_debug_pkg::ST_SEND_ACK: tx_start_o = ~tx_busy_i;
      uart_debug_pkg::ST_RD_SEND: begin
        tx_start_o = data_vld_q & ~tx_busy_i;
        tx_byte_o  = data_q;
      end
      uart_debug_pkg::ST_SEND_EOT: begin
        tx_start_o = ~tx_busy_i;
        tx_byte_o  = uart_debug_pkg::CODE_EOT;
      end
      uart_debug_pkg::ST_EOC_CODE: begin
        tx_start_o = ~tx_busy_i;
        tx_byte_o  = uart_debug_pkg::CODE_EOC;
      end
      uart_debug_pkg::ST_EOC_DATA: begin
        tx_start_o = ~tx_busy_i;
        tx_byte_o  = hdr_q[7:0];
      end
      default: tx_start_o = 1'b0;
    endcase
  end

  always_comb begin
    mem_req_o       = '0;
    mem_req_o.addr  = addr_q;
    mem_req_o.wdata = data_q;
    mem_req_o.write = (state_q == uart_debug_pkg::ST_WR_BYTE);
    mem_req_o.valid = (state_q == uart_debug_pkg::ST_RD_REQ) ||
                      ((state_q == uart_debug_pkg::ST_WR_BYTE) && data_vld_q);
  end

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= uart_debug_pkg::ST_IDLE;
      cnt_q      <= '0;
      data_vld_q <= 1'b0;
      launch_o   <= 1'b0;
    end else begin
      launch_o <= 1'b0;
      case (state_q)
        uart_debug_pkg::ST_IDLE: begin
          cnt_q <= '0;
          // EOC wins over a host byte in the same cycle
          if (eoc_i) begin
            hdr_q   <= exit_code_i;
            state_q <= uart_debug_pkg::ST_EOC_CODE;
          end else if (rx_valid_i) begin
            case (rx_byte_i)
              uart_debug_pkg::CODE_ACK: begin
                cmd_q   <= uart_debug_pkg::CODE_ACK;
                state_q <= uart_debug_pkg::ST_SEND_ACK;
              end
              uart_debug_pkg::CMD_READ, uart_debug_pkg::CMD_WRITE: begin
                cmd_q   <= uart_debug_pkg::dbg_cmd_e'(rx_byte_i);
                state_q <= uart_debug_pkg::ST_ADDR;
              end
              uart_debug_pkg::CMD_EXEC: begin
                cmd_q   <= uart_debug_pkg::CMD_EXEC;
                state_q <= uart_debug_pkg::ST_ENTRY;
              end
              default: state_q <= uart_debug_pkg::ST_IDLE;
            endcase
          end
        end
        uart_debug_pkg::ST_ADDR, uart_debug_pkg::ST_LEN, uart_debug_pkg::ST_ENTRY: begin
          if (rx_valid_i) begin
            hdr_q <= hdr_shift;
            cnt_q <= cnt_q + 1'b1;
          end
          if (last_hdr) begin
            cnt_q <= '0;
            if (state_q == uart_debug_pkg::ST_ADDR) begin
              addr_q  <= hdr_shift[uart_debug_pkg::MemAddrBits-1:0];
              state_q <= uart_debug_pkg::ST_LEN;
            end else begin
              if (state_q == uart_debug_pkg::ST_LEN) len_q <= hdr_shift;
              state_q <= uart_debug_pkg::ST_SEND_ACK;
            end
          end
        end
        uart_debug_pkg::ST_SEND_ACK: begin
          if (!tx_busy_i) begin
            case (cmd_q)
              uart_debug_pkg::CMD_EXEC: begin
                launch_o <= 1'b1;
                entry_o  <= hdr_q;
                state_q  <= uart_debug_pkg::ST_IDLE;
              end
              uart_debug_pkg::CMD_READ: state_q <= (len_q == '0) ?
                  uart_debug_pkg::ST_SEND_EOT : uart_debug_pkg::ST_RD_REQ;
              uart_debug_pkg::CMD_WRITE: state_q <= (len_q == '0) ?
                  uart_debug_pkg::ST_SEND_EOT : uart_debug_pkg::ST_WR_BYTE;
              default: state_q <= uart_debug_pkg::ST_IDLE;
            endcase
          end
        end
        uart_debug_pkg::ST_RD_REQ: begin
          if (mem_rsp_i.gnt) state_q <= uart_debug_pkg::ST_RD_SEND;
        end
        uart_debug_pkg::ST_RD_SEND: begin
          // Read data lands one cycle after grant, then waits for the transmitter
          if (mem_rsp_i.rvalid) begin
            data_q     <= mem_rsp_i.rdata;
            data_vld_q <= 1'b1;
          end else if (data_vld_q && !tx_busy_i) begin
            data_vld_q <= 1'b0;
            addr_q     <= addr_q + 1'b1;
            len_q      <= len_q - 1'b1;
            state_q    <= (len_q == 64'd1) ?
                uart_debug_pkg::ST_SEND_EOT : uart_debug_pkg::ST_RD_REQ;
          end
        end
        uart_debug_pkg::ST_WR_BYTE: begin
          if (!data_vld_q && rx_valid_i) begin
            data_q     <= rx_byte_i;
            data_vld_q <= 1'b1;
          end else if (data_vld_q && mem_rsp_i.gnt) begin
            data_vld_q <= 1'b0;
            addr_q     <= addr_q + 1'b1;
            len_q      <= len_q - 1'b1;
            if (len_q == 64'd1) state_q <= uart_debug_pkg::ST_SEND_EOT;
          end
        end
        uart_debug_pkg::ST_SEND_EOT: begin
          if (!tx_busy_i) state_q <= uart_debug_pkg::ST_IDLE;
        end
        uart_debug_pkg::ST_EOC_CODE: begin
          if (!tx_busy_i) state_q <= uart_debug_pkg::ST_EOC_DATA;
        end
        uart_debug_pkg::ST_EOC_DATA: begin
          // Exit code goes out LSB first
          if (!tx_busy_i) begin
            hdr_q <= hdr_q >> 8;
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CntLast) state_q <= uart_debug_pkg::ST_IDLE;
          end
        end
        default: state_q <= uart_debug_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

// ==== source/uart_debug_pkg.sv ====
// Scratch memory holds at most 2**MemAddrBits bytes; protocol fields are 64-bit, LSB first
package uart_debug_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned MemAddrBits = 10;
  // Bytes in an address, length, entry or exit code field
  localparam int unsigned HeaderBytes = 8;

  typedef logic [MemAddrBits-1:0] mem_addr_t;

  ////////////////////
  // Memory port
  ////////////////////

  typedef struct packed {
    logic      valid;
    logic      write;
    mem_addr_t addr;
    logic [7:0] wdata;
  } mem_req_t;

  typedef struct packed {
    // Request taken this cycle
    logic       gnt;
    logic       rvalid;
    logic [7:0] rdata;
  } mem_rsp_t;

  ////////////////////
  // Protocol
  ////////////////////

  typedef enum logic [7:0] {
    CODE_EOT  = 8'h04,
    CODE_ACK  = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13,
    CODE_EOC  = 8'h14
  } dbg_cmd_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_ENTRY,
    ST_SEND_ACK,
    ST_RD_REQ,
    ST_RD_SEND,
    ST_WR_BYTE,
    ST_SEND_EOT,
    ST_EOC_CODE,
    ST_EOC_DATA
  } engine_state_e;

endpackage

// ==== source/uart_debug_top.sv ====
// 8N1 UART debug target; ClksPerBit at least 4, MemDepth at most 2**MemAddrBits
`timescale 1ns/1ns
module uart_debug_top #(
  parameter int unsigned ClksPerBit = 16,
  parameter int unsigned MemDepth   = 1024
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     uart_rx_i,
  output logic                     uart_tx_o,
  input  uart_debug_pkg::mem_req_t ext_req_i,
  output uart_debug_pkg::mem_rsp_t ext_rsp_o,
  input  logic                     eoc_i,
  input  logic [63:0]              exit_code_i,
  output logic                     launch_o,
  output logic [63:0]              entry_o
);

  logic                     rx_valid;
  logic [7:0]               rx_byte;
  logic                     tx_start;
  logic [7:0]               tx_byte;
  logic                     tx_busy;
  uart_debug_pkg::mem_req_t eng_req;
  uart_debug_pkg::mem_rsp_t eng_rsp;

  ////////////////////
  // Serial side
  ////////////////////

  uart_rx #(
    .ClksPerBit(ClksPerBit)
  ) u_rx (
    .clk         (clk),
    .rst_i       (rst_i),
    .rx_i        (uart_rx_i),
    .byte_valid_o(rx_valid),
    .byte_o      (rx_byte)
  );

  uart_tx #(
    .ClksPerBit(ClksPerBit)
  ) u_tx (
    .clk    (clk),
    .rst_i  (rst_i),
    .start_i(tx_start),
    .byte_i (tx_byte),
    .busy_o (tx_busy),
    .tx_o   (uart_tx_o)
  );

  ////////////////////
  // Engine and memory
  ////////////////////

  uart_debug_engine u_engine (
    .clk        (clk),
    .rst_i      (rst_i),
    .rx_valid_i (rx_valid),
    .rx_byte_i  (rx_byte),
    .tx_busy_i  (tx_busy),
    .tx_start_o (tx_start),
    .tx_byte_o  (tx_byte),
    .mem_req_o  (eng_req),
    .mem_rsp_i  (eng_rsp),
    .eoc_i      (eoc_i),
    .exit_code_i(exit_code_i),
    .launch_o   (launch_o),
    .entry_o    (entry_o)
  );

  scratch_mem_arbiter #(
    .MemDepth(MemDepth)
  ) u_mem (
    .clk      (clk),
    .rst_i    (rst_i),
    .eng_req_i(eng_req),
    .eng_rsp_o(eng_rsp),
    .ext_req_i(ext_req_i),
    .ext_rsp_o(ext_rsp_o)
  );

endmodule

// ==== source/uart_rx.sv ====
// 8N1 only; ClksPerBit must be at least 4; frames with a low stop bit are dropped
`timescale 1ns/1ns
module uart_rx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       rx_i,
  output logic       byte_valid_o,
  output logic [7:0] byte_o
);

  localparam int unsigned CntBits = $clog2(ClksPerBit);
  localparam logic [CntBits-1:0] HalfBit = CntBits'(ClksPerBit / 2 - 1);
  localparam logic [CntBits-1:0] FullBit = CntBits'(ClksPerBit - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e          state_q;
  logic [1:0]         sync_q;
  logic [CntBits-1:0] cnt_q;
  logic [2:0]         bit_q;
  logic [7:0]         shift_q;
  logic               line;

  // Two-flop synchronizer, idles high like the line
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  assign line = sync_q[1];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q      <= RX_IDLE;
      cnt_q        <= '0;
      bit_q        <= '0;
      byte_valid_o <= 1'b0;
    end else begin
      byte_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          bit_q <= '0;
          if (!line) state_q <= RX_START;
        end
        RX_START: begin
          cnt_q <= cnt_q + 1'b1;
          // Recheck at mid start bit to reject glitches
          if (cnt_q == HalfBit) begin
            cnt_q   <= '0;
            state_q <= line ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == FullBit) begin
            cnt_q   <= '0;
            shift_q <= {line, shift_q[7:1]};
            bit_q   <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= RX_STOP;
          end
        end
        default: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == FullBit) begin
            byte_valid_o <= line;
            state_q      <= RX_IDLE;
          end
        end
      endcase
    end
  end

  assign byte_o = shift_q;

endmodule

// ==== source/uart_tx.sv ====
// 8N1 only; ClksPerBit must be at least 4; a start strobe while busy is ignored
`timescale 1ns/1ns
module uart_tx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       start_i,
  input  logic [7:0] byte_i,
  output logic       busy_o,
  output logic       tx_o
);

  localparam int unsigned CntBits = $clog2(ClksPerBit);
  localparam logic [CntBits-1:0] FullBit = CntBits'(ClksPerBit - 1);

  logic [9:0]         frame_q;
  logic [CntBits-1:0] cnt_q;
  logic [3:0]         bit_q;
  logic               busy_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      bit_q  <= '0;
    end else if (!busy_q) begin
      if (start_i) begin
        busy_q  <= 1'b1;
        // Stop bit, data LSB first, start bit
        frame_q <= {1'b1, byte_i, 1'b0};
        cnt_q   <= '0;
        bit_q   <= '0;
      end
    end else if (cnt_q == FullBit) begin
      cnt_q <= '0;
      if (bit_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_q   <= bit_q + 1'b1;
        frame_q <= {1'b1, frame_q[9:1]};
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign busy_o = busy_q;
  assign tx_o   = busy_q ? frame_q[0] : 1'b1;

endmodule

// ==== uart_debug.f ====
source/uart_debug_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_debug_engine.sv
source/scratch_mem_arbiter.sv
source/uart_debug_top.sv
sim/uart_debug_assert.sv
sim/tb_uart_debug.sv
